// ==== test/fetch_front_stim.txt ====
// cmd arg expect: 1 run N first_pc, 2 redirect target first_pc,
// 3 load addr data, 4 stall cycles next_pc, 0 end
1 00000006 00001000
3 00002000 a5a52000
1 00000004 00001018
2 00004000 00004000
1 00000005 00004000
4 00000014 00004014
1 00000003 00004014
3 00002004 a5a52004
3 00002008 a5a52008
1 00000008 00004020
2 00000800 00000800
3 0000200c a5a5200c
1 00000004 00000800
0 00000000 00000000

// ==== fetch_front.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/i_queue.sv
rtl/mem_arbiter.sv
rtl/fetch_unit.sv
rtl/fetch_front.sv
test/fetch_front_assert.sv
test/fetch_front_tb.sv

// ==== Makefile ====
# Verilator build and run of the front end testbench

VERILATOR ?= verilator
TOP       ?= fetch_front_tb
RTL_TOP   ?= fetch_front
FLIST     ?= fetch_front.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD)

// ==== test/fetch_front_tb.sv ====
//////////////////////////////
// Front end testbench: memory model,
// stim file commands, decoder and load checks
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_front_tb import fetch_pkg::*; ();

    localparam logic [31:0] MEM_XOR = 32'hA5A5_0000;

    logic                     clk = 1'b0;
    logic                     arst_n = 1'b0;
    logic                     redirect_valid = 1'b0;
    logic [`FETCH_ADDR_W-1:0] redirect_pc = '0;
    logic                     dec_valid;
    logic                     dec_ready = 1'b0;
    i_queue_data_t            dec_data;
    logic                     ld_valid = 1'b0;
    logic                     ld_ready;
    logic [`FETCH_ADDR_W-1:0] ld_addr = '0;
    logic                     lq_valid;
    logic                     lq_ready = 1'b0;
    load_resp_t               lq_data;
    logic                     mem_req_valid;
    logic                     mem_req_ready = 1'b0;
    logic [`FETCH_ADDR_W-1:0] mem_addr;
    logic                     mem_resp_valid = 1'b0;
    logic [31:0]              mem_rdata = '0;

    logic [31:0] stim [0:63];
    logic [31:0] seed = 32'h88b3_7b38;
    logic [31:0] exp_pc;
    logic [31:0] ld_exp_addr [$];
    logic [31:0] ld_exp_data [$];
    logic        xfer_seen = 1'b0;
    logic [31:0] xfer_addr = '0;
    logic        pend_valid = 1'b0;
    logic [31:0] pend_addr = '0;
    int          pend_cnt = 0;

    fetch_front i_fetch_front (
        .clk            (clk),
        .arst_n         (arst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .dec_valid      (dec_valid),
        .dec_ready      (dec_ready),
        .dec_data       (dec_data),
        .ld_valid       (ld_valid),
        .ld_ready       (ld_ready),
        .ld_addr        (ld_addr),
        .lq_valid       (lq_valid),
        .lq_ready       (lq_ready),
        .lq_data        (lq_data),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_addr       (mem_addr),
        .mem_resp_valid (mem_resp_valid),
        .mem_rdata      (mem_rdata)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_low(input string name, input logic value);
        assert (value === 1'b0)
            else report_failure($sformatf("Error: %0t %s got %b expected 0",
                $time, name, value));
    endtask

    // Memory model, one word per address, latency 1 to 4 cycles
    always @(negedge clk) begin
        xfer_seen = mem_req_valid && mem_req_ready;
        xfer_addr = mem_addr;
    end

    always @(posedge clk) begin
        #1;
        seed = lcg_step(seed);
        mem_req_ready = seed[31] | seed[30];
        mem_resp_valid = 1'b0;
        if (xfer_seen && arst_n) begin
            pend_valid = 1'b1;
            pend_addr  = xfer_addr;
            pend_cnt   = int'(seed[29:28]);
        end
        if (pend_valid) begin
            if (pend_cnt == 0) begin
                mem_resp_valid = 1'b1;
                mem_rdata      = pend_addr ^ MEM_XOR;
                pend_valid     = 1'b0;
            end else begin
                pend_cnt = pend_cnt - 1;
            end
        end
    end

    // Load responses must come back in issue order
    always @(negedge clk) begin
        if (arst_n && lq_valid && lq_ready) begin
            assert (ld_exp_addr.size() > 0)
                else report_failure("Load response arrived with no load outstanding");
            assert (lq_data.addr == ld_exp_addr[0])
                else report_failure($sformatf("Error: %0t lq_data.addr got %h expected %h",
                    $time, lq_data.addr, ld_exp_addr[0]));
            assert (lq_data.data == ld_exp_data[0])
                else report_failure($sformatf("Error: %0t lq_data.data got %h expected %h",
                    $time, lq_data.data, ld_exp_data[0]));
            void'(ld_exp_addr.pop_front());
            void'(ld_exp_data.pop_front());
        end
    end

    task automatic check_entry();
        assert (dec_data.pc == exp_pc)
            else report_failure($sformatf("Error: %0t dec_data.pc got %h expected %h",
                $time, dec_data.pc, exp_pc));
        assert (dec_data.next_pc == exp_pc + 32'd4)
            else report_failure($sformatf("Error: %0t dec_data.next_pc got %h expected %h",
                $time, dec_data.next_pc, exp_pc + 32'd4));
        assert (dec_data.instr == (exp_pc ^ MEM_XOR))
            else report_failure($sformatf("Error: %0t dec_data.instr got %h expected %h",
                $time, dec_data.instr, exp_pc ^ MEM_XOR));
    endtask

    task automatic run_instrs(input int count, input logic [31:0] first_pc);
        int got;
        int waited;
        got = 0;
        waited = 0;
        assert (first_pc == exp_pc)
            else report_failure($sformatf("Stimulus expects pc %h next but fetch is at %h",
                first_pc, exp_pc));
        while (got < count) begin
            @(posedge clk);
            #1 dec_ready = 1'b1;
            @(negedge clk);
            if (dec_valid) begin
                check_entry();
                exp_pc = exp_pc + 32'd4;
                got = got + 1;
                waited = 0;
            end else begin
                waited = waited + 1;
                assert (waited < 100)
                    else report_failure("Timeout waiting for an instruction at the decoder");
            end
        end
        @(posedge clk);
        #1 dec_ready = 1'b0;
    endtask

    task automatic redirect_to(input logic [31:0] target, input logic [31:0] first_pc);
        @(posedge clk);
        #1;
        redirect_valid = 1'b1;
        redirect_pc = target;
        @(posedge clk);
        #1 redirect_valid = 1'b0;
        exp_pc = target;
        assert (first_pc == target)
            else report_failure("Stimulus redirect target and expected pc disagree");
    endtask

    task automatic issue_load(input logic [31:0] addr, input logic [31:0] data);
        int waited;
        waited = 0;
        assert (data == (addr ^ MEM_XOR))
            else report_failure("Stimulus load data does not match the memory contents");
        @(posedge clk);
        #1;
        ld_valid = 1'b1;
        ld_addr = addr;
        @(negedge clk);
        while (!ld_ready) begin
            waited = waited + 1;
            assert (waited < 200) else report_failure("Timeout waiting for ld_ready");
            @(negedge clk);
        end
        ld_exp_addr.push_back(addr);
        ld_exp_data.push_back(data);
        @(posedge clk);
        #1 ld_valid = 1'b0;
    endtask

    task automatic stall_decoder(input int cycles, input logic [31:0] next_pc);
        repeat (cycles) @(posedge clk);
        @(negedge clk);
        assert (dec_valid === 1'b1)
            else report_failure($sformatf("Error: %0t dec_valid got %b expected 1",
                $time, dec_valid));
        assert (dec_data.pc == next_pc)
            else report_failure($sformatf("Error: %0t dec_data.pc got %h expected %h",
                $time, dec_data.pc, next_pc));
    endtask

    initial begin
        int idx;
        int waited;
        logic [31:0] cmd;
        $readmemh("test/fetch_front_stim.txt", stim);
        repeat (5) begin
            @(negedge clk);
            expect_low("mem_req_valid", mem_req_valid);
            expect_low("dec_valid", dec_valid);
            expect_low("lq_valid", lq_valid);
            expect_low("ld_ready", ld_ready);
        end
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        lq_ready = 1'b1;
        exp_pc = `FETCH_RESET_PC;
        idx = 0;
        cmd = stim[0];
        while (cmd != 32'd0) begin
            case (cmd)
                32'd1:   run_instrs(int'(stim[idx+1]), stim[idx+2]);
                32'd2:   redirect_to(stim[idx+1], stim[idx+2]);
                32'd3:   issue_load(stim[idx+1], stim[idx+2]);
                32'd4:   stall_decoder(int'(stim[idx+1]), stim[idx+2]);
                default: report_failure("Unknown command in the stimulus file");
            endcase
            idx = idx + 3;
            cmd = stim[idx];
        end
        waited = 0;
        while (ld_exp_addr.size() != 0) begin
            @(negedge clk);
            waited = waited + 1;
            assert (waited < 200) else report_failure("Timeout waiting for load responses");
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : fetch_front_tb

`default_nettype wire

// ==== test/fetch_front_assert.sv ====
//////////////////////////////
// Bound checks on bus handshake,
// queue occupancy and redirect
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_front_assert (
    input logic                                 clk,
    input logic                                 arst_n,
    input logic                                 mem_req_valid,
    input logic                                 mem_req_ready,
    input logic [`FETCH_ADDR_W-1:0]             mem_addr,
    input logic                                 iq_push_valid,
    input logic [$clog2(`FETCH_IQ_DEPTH+1)-1:0] iq_count,
    input logic                                 dec_valid,
    input logic                                 dec_ready,
    input logic                                 load_resp_valid,
    input logic [$clog2(`FETCH_LQ_DEPTH+1)-1:0] lq_count,
    input logic                                 lq_ready,
    input logic                                 redirect_valid
);

    // Request held with a steady address until the bus takes it
    req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_addr))
        else $error("memory request dropped or changed before ready");

    // A full queue only takes a push when it pops in the same cycle
    iq_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        iq_push_valid && iq_count == `FETCH_IQ_DEPTH |-> dec_ready)
        else $error("instruction queue pushed while full");

    lq_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        load_resp_valid && lq_count == `FETCH_LQ_DEPTH |-> lq_ready)
        else $error("load queue pushed while full");

    // Flush leaves nothing for the decoder
    redirect_empty: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid |=> !dec_valid)
        else $error("decoder valid in the cycle after a redirect");

endmodule : fetch_front_assert

bind fetch_front fetch_front_assert i_fetch_front_assert (
    .clk             (clk),
    .arst_n          (arst_n),
    .mem_req_valid   (mem_req_valid),
    .mem_req_ready   (mem_req_ready),
    .mem_addr        (mem_addr),
    .iq_push_valid   (iq_push_valid),
    .iq_count        (iq_count),
    .dec_valid       (dec_valid),
    .dec_ready       (dec_ready),
    .load_resp_valid (load_resp_valid),
    .lq_count        (lq_count),
    .lq_ready        (lq_ready),
    .redirect_valid  (redirect_valid)
);

`default_nettype wire

// ==== rtl/fetch_front.sv ====
//////////////////////////////
// Front end top: fetch, load port,
// bus arbiter and the two queues
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_front import fetch_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,

    // Redirect from branch resolution
    input  logic                     redirect_valid,
    input  logic [`FETCH_ADDR_W-1:0] redirect_pc,

    // Decoder
    output logic                     dec_valid,
    input  logic                     dec_ready,
    output i_queue_data_t            dec_data,

    // Load port
    input  logic                     ld_valid,
    output logic                     ld_ready,
    input  logic [`FETCH_ADDR_W-1:0] ld_addr,
    output logic                     lq_valid,
    input  logic                     lq_ready,
    output load_resp_t               lq_data,

    // External memory bus
    output logic                     mem_req_valid,
    input  logic                     mem_req_ready,
    output logic [`FETCH_ADDR_W-1:0] mem_addr,
    input  logic                     mem_resp_valid,
    input  logic [31:0]              mem_rdata
);

    localparam int IQ_CNT_W = $clog2(`FETCH_IQ_DEPTH + 1);
    localparam int LQ_CNT_W = $clog2(`FETCH_LQ_DEPTH + 1);

    logic                     fetch_req_valid;
    logic [`FETCH_ADDR_W-1:0] fetch_req_addr;
    logic                     fetch_req_ready;
    logic                     fetch_resp_valid;
    logic [31:0]              fetch_resp_data;
    logic                     load_req_valid;
    logic                     load_req_ready;
    logic                     load_resp_valid;
    load_resp_t               load_resp_data;
    logic                     iq_push_valid;
    i_queue_data_t            iq_push_data;
    logic                     iq_flush;
    logic [IQ_CNT_W-1:0]      iq_count;
    logic [LQ_CNT_W-1:0]      lq_count;
    logic                     lq_free;

    // The arbiter stays busy through the response cycle, so lq_count already
    // holds the previous load by the time a new one can be accepted
    assign lq_free        = lq_count < LQ_CNT_W'(`FETCH_LQ_DEPTH);
    assign load_req_valid = ld_valid && lq_free;
    assign ld_ready       = load_req_ready && lq_free;

    fetch_unit u_fetch (
        .clk            (clk),
        .arst_n         (arst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .iq_count       (iq_count),
        .req_valid      (fetch_req_valid),
        .req_addr       (fetch_req_addr),
        .req_ready      (fetch_req_ready),
        .resp_valid     (fetch_resp_valid),
        .resp_data      (fetch_resp_data),
        .push_valid     (iq_push_valid),
        .push_data      (iq_push_data),
        .flush          (iq_flush)
    );

    mem_arbiter u_arb (
        .clk              (clk),
        .arst_n           (arst_n),
        .fetch_req_valid  (fetch_req_valid),
        .fetch_req_addr   (fetch_req_addr),
        .fetch_req_ready  (fetch_req_ready),
        .fetch_resp_valid (fetch_resp_valid),
        .fetch_resp_data  (fetch_resp_data),
        .load_req_valid   (load_req_valid),
        .load_req_addr    (ld_addr),
        .load_req_ready   (load_req_ready),
        .load_resp_valid  (load_resp_valid),
        .load_resp_data   (load_resp_data),
        .mem_req_valid    (mem_req_valid),
        .mem_req_ready    (mem_req_ready),
        .mem_addr         (mem_addr),
        .mem_resp_valid   (mem_resp_valid),
        .mem_rdata        (mem_rdata)
    );

    // Fetch credit guarantees room, push side ready not needed
    i_queue #(
        .payload_t (i_queue_data_t),
        .DEPTH     (`FETCH_IQ_DEPTH)
    ) u_iq (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (iq_flush),
        .in_valid  (iq_push_valid),
        .in_ready  (),
        .in_data   (iq_push_data),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .out_data  (dec_data),
        .count     (iq_count)
    );

    // Load responses, never flushed
    i_queue #(
        .payload_t (load_resp_t),
        .DEPTH     (`FETCH_LQ_DEPTH)
    ) u_lq (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (1'b0),
        .in_valid  (load_resp_valid),
        .in_ready  (),
        .in_data   (load_resp_data),
        .out_valid (lq_valid),
        .out_ready (lq_ready),
        .out_data  (lq_data),
        .count     (lq_count)
    );

endmodule : fetch_front

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
//////////////////////////////
// Fetch unit: pc, request issue against
// queue credit, redirect and stale discard
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_unit import fetch_pkg::*; (
    input  logic                                clk,
    input  logic                                arst_n,

    // Branch resolution stand-in
    input  logic                                redirect_valid,
    input  logic [`FETCH_ADDR_W-1:0]            redirect_pc,

    // Occupancy of the instruction queue
    input  logic [$clog2(`FETCH_IQ_DEPTH+1)-1:0] iq_count,

    // Request and response through the arbiter
    output logic                                req_valid,
    output logic [`FETCH_ADDR_W-1:0]            req_addr,
    input  logic                                req_ready,
    input  logic                                resp_valid,
    input  logic [31:0]                         resp_data,

    // Instruction queue push side
    output logic                                push_valid,
    output i_queue_data_t                       push_data,
    output logic                                flush
);

    localparam int IQ_CNT_W = $clog2(`FETCH_IQ_DEPTH + 1);
    localparam logic [IQ_CNT_W:0] IQ_DEPTH = `FETCH_IQ_DEPTH;

    logic [`FETCH_ADDR_W-1:0] pc;
    logic [`FETCH_ADDR_W-1:0] pc_plus4;
    logic [`FETCH_ADDR_W-1:0] req_addr_q;
    logic                     req_q;
    logic                     wait_q;
    logic                     stale_q;
    logic                     outstanding;
    logic [IQ_CNT_W:0]        used;
    logic                     credit_ok;
    logic                     issue;
    logic                     xfer;
    logic                     accept;

    // No prediction, always the next word
    assign pc_plus4 = pc + `FETCH_ADDR_W'(4);

    // Queued entries plus the fetch in flight must stay below the depth,
    // so a response always finds a free slot
    assign outstanding = req_q || wait_q;
    assign used        = {1'b0, iq_count} + {{IQ_CNT_W{1'b0}}, outstanding};
    assign credit_ok   = used < IQ_DEPTH;

    assign issue  = !outstanding && credit_ok && !redirect_valid;
    assign xfer   = req_q && req_ready;
    assign accept = resp_valid && !stale_q && !redirect_valid;

    assign req_valid = req_q;
    assign req_addr  = req_addr_q;
    assign flush     = redirect_valid;

    // pc only moves on a push or a redirect, so it still names the fetched word
    assign push_valid = accept;
    assign push_data  = '{pc: pc, next_pc: pc_plus4, instr: resp_data};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= `FETCH_RESET_PC;
            req_q   <= 1'b0;
            wait_q  <= 1'b0;
            stale_q <= 1'b0;
        end else begin
            if (issue) begin
                req_q <= 1'b1;
            end else if (xfer) begin
                req_q <= 1'b0;
            end

            if (xfer) begin
                wait_q <= 1'b1;
            end else if (resp_valid) begin
                wait_q <= 1'b0;
            end

            if (redirect_valid) begin
                pc <= redirect_pc;
                // Whatever is still outstanding belongs to the old path
                stale_q <= req_q || (wait_q && !resp_valid);
            end else begin
                if (accept) begin
                    pc <= pc_plus4;
                end
                if (resp_valid) begin
                    stale_q <= 1'b0;
                end
            end
        end
    end

    // Address held steady until the bus takes it
    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr_q <= pc;
        end
    end

endmodule : fetch_unit

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
//////////////////////////////
// Memory bus arbiter, load port over fetch,
// one transaction in flight
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module mem_arbiter import fetch_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,

    // Fetch side
    input  logic                     fetch_req_valid,
    input  logic [`FETCH_ADDR_W-1:0] fetch_req_addr,
    output logic                     fetch_req_ready,
    output logic                     fetch_resp_valid,
    output logic [31:0]              fetch_resp_data,

    // Load side
    input  logic                     load_req_valid,
    input  logic [`FETCH_ADDR_W-1:0] load_req_addr,
    output logic                     load_req_ready,
    output logic                     load_resp_valid,
    output load_resp_t               load_resp_data,

    // External memory bus
    output logic                     mem_req_valid,
    input  logic                     mem_req_ready,
    output logic [`FETCH_ADDR_W-1:0] mem_addr,
    input  logic                     mem_resp_valid,
    input  logic [31:0]              mem_rdata
);

    logic                     settled;
    logic                     busy;
    logic                     hold;
    mem_owner_e               owner;
    mem_owner_e               grant;
    logic                     bus_free;
    logic                     load_win;
    logic                     fetch_win;
    logic [`FETCH_ADDR_W-1:0] load_addr_q;

    // A request left waiting on the bus keeps its owner until it transfers,
    // so a late load cannot swap the address under a pending fetch
    assign grant     = hold ? owner : (load_req_valid ? OWNER_LOAD : OWNER_FETCH);
    assign load_win  = hold ? (owner == OWNER_LOAD) : 1'b1;
    assign fetch_win = hold ? (owner == OWNER_FETCH) : !load_req_valid;

    assign bus_free = settled && !busy && mem_req_ready;

    assign mem_req_valid = settled && !busy && (hold || load_req_valid || fetch_req_valid);
    assign mem_addr      = (grant == OWNER_LOAD) ? load_req_addr : fetch_req_addr;

    assign load_req_ready  = bus_free && load_win;
    assign fetch_req_ready = bus_free && fetch_win;

    // Responses go back to whoever owns the transaction
    assign fetch_resp_valid = mem_resp_valid && busy && (owner == OWNER_FETCH);
    assign load_resp_valid  = mem_resp_valid && busy && (owner == OWNER_LOAD);
    assign fetch_resp_data  = mem_rdata;
    assign load_resp_data   = '{addr: load_addr_q, data: mem_rdata};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            settled <= 1'b0;
            busy    <= 1'b0;
            hold    <= 1'b0;
            owner   <= OWNER_FETCH;
        end else begin
            settled <= 1'b1;
            if (mem_req_valid) begin
                owner <= grant;
                hold  <= !mem_req_ready;
                busy  <= mem_req_ready;
            end else if (busy && mem_resp_valid) begin
                busy  <= 1'b0;
                owner <= OWNER_FETCH;
            end
        end
    end

    // Address of the load in flight, returned with its data
    always_ff @(posedge clk) begin
        if (mem_req_valid && mem_req_ready && grant == OWNER_LOAD) begin
            load_addr_q <= load_req_addr;
        end
    end

endmodule : mem_arbiter

`default_nettype wire

// ==== rtl/i_queue.sv ====
//////////////////////////////
// Circular FIFO with valid/ready
// on both sides and a flush
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module i_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = `FETCH_IQ_DEPTH
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       flush,

    // Push side
    input  logic                       in_valid,
    output logic                       in_ready,
    input  payload_t                   in_data,

    // Pop side, head entry shown while valid
    output logic                       out_valid,
    input  logic                       out_ready,
    output payload_t                   out_data,

    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] cnt;
    logic             full;
    logic             push;
    logic             pop;

    // Pointer step with wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (cnt == CNT_W'(DEPTH));
    assign out_valid = (cnt != '0);
    assign out_data  = mem[head];
    assign count     = cnt;

    // A pop frees the slot the push needs
    assign in_ready = !full || out_ready;
    assign push     = in_valid && in_ready && !flush;
    assign pop      = out_valid && out_ready && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
            tail <= '0;
            cnt  <= '0;
        end else if (flush) begin
            head <= '0;
            tail <= '0;
            cnt  <= '0;
        end else begin
            if (push) begin
                tail <= ptr_inc(tail);
            end
            if (pop) begin
                head <= ptr_inc(head);
            end
            case ({push, pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

    // Storage, seen at the output one cycle after the push
    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= in_data;
        end
    end

endmodule : i_queue

`default_nettype wire

// ==== rtl/fetch_pkg.sv ====
//////////////////////////////
// Front end types: queue entries and bus owner
//////////////////////////////

`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

    // One instruction queue entry, 96 bits
    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] pc;
        logic [`FETCH_ADDR_W-1:0] next_pc;
        logic [31:0]              instr;
    } i_queue_data_t;

    // Load response with the address it came from
    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] addr;
        logic [31:0]              data;
    } load_resp_t;

    // Requester that holds the memory bus
    typedef enum logic {
        OWNER_FETCH = 1'b0,
        OWNER_LOAD  = 1'b1
    } mem_owner_e;

endpackage : fetch_pkg

`default_nettype wire

// ==== rtl/fetch_defs.svh ====
//////////////////////////////
// Front end sizing: address width, queue depths, reset pc
//////////////////////////////

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Byte address width of the memory bus
`define FETCH_ADDR_W 32

// Instruction queue entries
`define FETCH_IQ_DEPTH 8

// Load response queue entries
`define FETCH_LQ_DEPTH 4

// First pc fetched after reset
`define FETCH_RESET_PC 32'h0000_1000

`endif
